//--- src/mips_cfg.svh
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// Address of the first instruction after reset
`define RESET_VECTOR 32'hBFC00000

// Fetching this address ends the program
`define HALT_ADDR 32'h00000000

// General purpose register file size
`define REG_COUNT 32

// Register shown on the register_v0 port
`define REG_V0 2

`endif

//--- src/mips_pkg.sv
`default_nettype none

package mips_pkg;

  // Primary opcode field, instr[31:26]
  typedef enum logic [5:0] {
    op_special = 6'h00,
    op_j       = 6'h02,
    op_jal     = 6'h03,
    op_beq     = 6'h04,
    op_bne     = 6'h05,
    op_addiu   = 6'h09,
    op_slti    = 6'h0a,
    op_andi    = 6'h0c,
    op_ori     = 6'h0d,
    op_xori    = 6'h0e,
    op_lui     = 6'h0f,
    op_lw      = 6'h23,
    op_sw      = 6'h2b
  } opcode_t;

  // Function field of R-type instructions, instr[5:0]
  typedef enum logic [5:0] {
    f_sll  = 6'h00,
    f_srl  = 6'h02,
    f_jr   = 6'h08,
    f_addu = 6'h21,
    f_subu = 6'h23,
    f_and  = 6'h24,
    f_or   = 6'h25,
    f_xor  = 6'h26,
    f_slt  = 6'h2a,
    f_sltu = 6'h2b
  } funct_t;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt,
    alu_sltu,
    alu_sll,
    alu_srl,
    alu_lui
  } alu_op_t;

  // Where the register write value comes from
  typedef enum logic [1:0] {
    wb_alu,
    wb_mem,
    wb_link
  } wb_src_t;

endpackage

`default_nettype wire

//--- src/mips_fetch.sv
`timescale 1ns/1ns
`default_nettype none

`include "mips_cfg.svh"

module mips_fetch (
  input  logic        clk,
  input  logic        reset,
  input  logic        clk_enable,
  input  logic        redirect,
  input  logic        is_jump,
  input  logic        jump_reg,
  input  logic [31:0] branch_target,
  input  logic [31:0] jump_target,
  input  logic [31:0] rs_data,
  output logic [31:0] instr_address,
  output logic [31:0] pc_plus8,
  output logic        active
);

  logic [31:0] pc_plus4;
  logic [31:0] next_pc;
  logic [31:0] redirect_target;
  // Target held across the delay slot
  logic [31:0] delay_target;
  logic        delay_pending;

  assign pc_plus4 = instr_address + 32'd4;
  // Link address skips the delay slot
  assign pc_plus8 = instr_address + 32'd8;

  assign next_pc = delay_pending ? delay_target : pc_plus4;

  always_comb
  begin
    if (is_jump && jump_reg)
      redirect_target = rs_data;
    else if (is_jump)
      redirect_target = jump_target;
    else
      redirect_target = branch_target;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      instr_address <= `RESET_VECTOR;
      delay_pending <= 1'b0;
      active        <= 1'b1;
    end
    else if (clk_enable)
    begin
      instr_address <= next_pc;
      delay_pending <= redirect;
      if (instr_address == `HALT_ADDR)
        active <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (clk_enable && redirect)
      delay_target <= redirect_target;
  end

endmodule

`default_nettype wire

//--- src/mips_decode.sv
`timescale 1ns/1ns
`default_nettype none

module mips_decode (
  input  logic [31:0]       instr,
  input  logic [31:0]       instr_address,
  output logic [4:0]        rs_addr,
  output logic [4:0]        rt_addr,
  output logic [4:0]        dst_addr,
  output logic [4:0]        shamt,
  output mips_pkg::alu_op_t alu_op,
  output logic [31:0]       imm_ext,
  output logic              reg_write,
  output logic              alu_src_imm,
  output logic              mem_read,
  output logic              mem_write,
  output logic              is_branch,
  output logic              branch_ne,
  output logic              is_jump,
  output logic              jump_reg,
  output mips_pkg::wb_src_t wb_src,
  output logic [31:0]       branch_target,
  output logic [31:0]       jump_target
);

  import mips_pkg::*;

  opcode_t     opcode;
  funct_t      funct;
  logic [15:0] imm;
  logic [31:0] pc_plus4;
  logic        sign_ext;

  assign opcode  = opcode_t'(instr[31:26]);
  assign funct   = funct_t'(instr[5:0]);
  assign imm     = instr[15:0];
  assign rs_addr = instr[25:21];
  assign rt_addr = instr[20:16];
  assign shamt   = instr[10:6];

  // Logic immediates are zero-extended, the rest sign-extended
  assign imm_ext = sign_ext ? {{16{imm[15]}}, imm} : {16'b0, imm};

  assign pc_plus4      = instr_address + 32'd4;
  assign branch_target = pc_plus4 + {{14{imm[15]}}, imm, 2'b00};
  assign jump_target   = {pc_plus4[31:28], instr[25:0], 2'b00};

  always_comb
  begin
    dst_addr    = instr[20:16];
    alu_op      = alu_add;
    reg_write   = 1'b0;
    alu_src_imm = 1'b0;
    mem_read    = 1'b0;
    mem_write   = 1'b0;
    is_branch   = 1'b0;
    branch_ne   = 1'b0;
    is_jump     = 1'b0;
    jump_reg    = 1'b0;
    wb_src      = wb_alu;
    sign_ext    = 1'b1;

    case (opcode)
      op_special:
      begin
        dst_addr  = instr[15:11];
        reg_write = 1'b1;
        case (funct)
          f_sll:  alu_op = alu_sll;
          f_srl:  alu_op = alu_srl;
          f_addu: alu_op = alu_add;
          f_subu: alu_op = alu_sub;
          f_and:  alu_op = alu_and;
          f_or:   alu_op = alu_or;
          f_xor:  alu_op = alu_xor;
          f_slt:  alu_op = alu_slt;
          f_sltu: alu_op = alu_sltu;
          f_jr:
          begin
            reg_write = 1'b0;
            is_jump   = 1'b1;
            jump_reg  = 1'b1;
          end
          default: reg_write = 1'b0;
        endcase
      end
      op_j: is_jump = 1'b1;
      op_jal:
      begin
        is_jump   = 1'b1;
        reg_write = 1'b1;
        dst_addr  = 5'd31;
        wb_src    = wb_link;
      end
      // Branch condition comes from the ALU equality flag on rs and rt
      op_beq: is_branch = 1'b1;
      op_bne:
      begin
        is_branch = 1'b1;
        branch_ne = 1'b1;
      end
      op_addiu:
      begin
        reg_write   = 1'b1;
        alu_src_imm = 1'b1;
      end
      op_slti:
      begin
        reg_write   = 1'b1;
        alu_src_imm = 1'b1;
        alu_op      = alu_slt;
      end
      op_andi:
      begin
        reg_write   = 1'b1;
        alu_src_imm = 1'b1;
        alu_op      = alu_and;
        sign_ext    = 1'b0;
      end
      op_ori:
      begin
        reg_write   = 1'b1;
        alu_src_imm = 1'b1;
        alu_op      = alu_or;
        sign_ext    = 1'b0;
      end
      op_xori:
      begin
        reg_write   = 1'b1;
        alu_src_imm = 1'b1;
        alu_op      = alu_xor;
        sign_ext    = 1'b0;
      end
      op_lui:
      begin
        reg_write   = 1'b1;
        alu_src_imm = 1'b1;
        alu_op      = alu_lui;
      end
      op_lw:
      begin
        reg_write   = 1'b1;
        alu_src_imm = 1'b1;
        mem_read    = 1'b1;
        wb_src      = wb_mem;
      end
      op_sw:
      begin
        alu_src_imm = 1'b1;
        mem_write   = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

//--- src/mips_regfile.sv
`timescale 1ns/1ns
`default_nettype none

`include "mips_cfg.svh"

module mips_regfile (
  input  logic        clk,
  input  logic        reset,
  input  logic        clk_enable,
  input  logic        reg_write,
  input  logic [4:0]  rs_addr,
  input  logic [4:0]  rt_addr,
  input  logic [4:0]  dst_addr,
  input  logic [31:0] write_data,
  output logic [31:0] rs_data,
  output logic [31:0] rt_data,
  output logic [31:0] register_v0
);

  logic [31:0] regs [0:`REG_COUNT-1];

  // Register 0 is never written, so it reads back as 0
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < `REG_COUNT; i++)
        regs[i] <= 32'b0;
    end
    else if (clk_enable && reg_write && (dst_addr != 5'd0))
    begin
      regs[dst_addr] <= write_data;
    end
  end

  assign rs_data     = regs[rs_addr];
  assign rt_data     = regs[rt_addr];
  assign register_v0 = regs[`REG_V0];

endmodule

`default_nettype wire

//--- src/mips_alu.sv
`timescale 1ns/1ns
`default_nettype none

module mips_alu (
  input  mips_pkg::alu_op_t alu_op,
  input  logic [31:0]       a,
  input  logic [31:0]       b,
  input  logic [4:0]        shamt,
  output logic [31:0]       result,
  output logic              zero
);

  import mips_pkg::*;

  // Equality of the two operands drives beq and bne
  assign zero = (a == b);

  always_comb
  begin
    case (alu_op)
      alu_add:  result = a + b;
      alu_sub:  result = a - b;
      alu_and:  result = a & b;
      alu_or:   result = a | b;
      alu_xor:  result = a ^ b;
      alu_slt:  result = {31'b0, $signed(a) < $signed(b)};
      alu_sltu: result = {31'b0, a < b};
      // Shifts act on rt, amount from the shamt field
      alu_sll:  result = b << shamt;
      alu_srl:  result = b >> shamt;
      alu_lui:  result = {b[15:0], 16'b0};
      default:  result = a + b;
    endcase
  end

endmodule

`default_nettype wire

//--- src/mips_mem_stage.sv
`timescale 1ns/1ns
`default_nettype none

module mips_mem_stage (
  input  logic              clk_enable,
  input  logic              mem_read,
  input  logic              mem_write,
  input  mips_pkg::wb_src_t wb_src,
  input  logic [31:0]       alu_result,
  input  logic [31:0]       rt_data,
  input  logic [31:0]       data_readdata,
  input  logic [31:0]       pc_plus8,
  output logic [31:0]       data_address,
  output logic [31:0]       data_writedata,
  output logic [31:0]       write_data,
  output logic              data_read,
  output logic              data_write
);

  import mips_pkg::*;

  // Word accesses only, low address bits dropped
  assign data_address   = {alu_result[31:2], 2'b00};
  assign data_writedata = rt_data;
  assign data_read      = mem_read;
  // No store while the core is frozen
  assign data_write     = mem_write & clk_enable;

  always_comb
  begin
    case (wb_src)
      wb_mem:  write_data = data_readdata;
      wb_link: write_data = pc_plus8;
      default: write_data = alu_result;
    endcase
  end

endmodule

`default_nettype wire

//--- src/mips_cpu_harvard.sv
`timescale 1ns/1ns
`default_nettype none

module mips_cpu_harvard (
  input  logic        clk,
  input  logic        reset,
  input  logic        clk_enable,
  output logic        active,
  output logic [31:0] register_v0,
  output logic [31:0] instr_address,
  input  logic [31:0] instr_readdata,
  output logic [31:0] data_address,
  output logic        data_write,
  output logic        data_read,
  output logic [31:0] data_writedata,
  input  logic [31:0] data_readdata
);

  import mips_pkg::*;

  logic [4:0]  rs_addr;
  logic [4:0]  rt_addr;
  logic [4:0]  dst_addr;
  logic [4:0]  shamt;
  alu_op_t     alu_op;
  wb_src_t     wb_src;
  logic [31:0] imm_ext;
  logic        reg_write;
  logic        alu_src_imm;
  logic        mem_read;
  logic        mem_write;
  logic        is_branch;
  logic        branch_ne;
  logic        is_jump;
  logic        jump_reg;
  logic [31:0] branch_target;
  logic [31:0] jump_target;
  logic [31:0] rs_data;
  logic [31:0] rt_data;
  logic [31:0] alu_b;
  logic [31:0] alu_result;
  logic        zero;
  logic        redirect;
  logic [31:0] pc_plus8;
  logic [31:0] write_data;

  // Jumps always redirect, branches when equality matches the sense
  assign redirect = is_jump | (is_branch & (zero != branch_ne));

  // Second ALU operand
  assign alu_b = alu_src_imm ? imm_ext : rt_data;

  mips_fetch fetch (
    .clk(clk), .reset(reset), .clk_enable(clk_enable),
    .redirect(redirect), .is_jump(is_jump), .jump_reg(jump_reg),
    .branch_target(branch_target), .jump_target(jump_target), .rs_data(rs_data),
    .instr_address(instr_address), .pc_plus8(pc_plus8), .active(active)
  );

  mips_decode decode (
    .instr(instr_readdata), .instr_address(instr_address),
    .rs_addr(rs_addr), .rt_addr(rt_addr), .dst_addr(dst_addr), .shamt(shamt),
    .alu_op(alu_op), .imm_ext(imm_ext),
    .reg_write(reg_write), .alu_src_imm(alu_src_imm),
    .mem_read(mem_read), .mem_write(mem_write),
    .is_branch(is_branch), .branch_ne(branch_ne),
    .is_jump(is_jump), .jump_reg(jump_reg), .wb_src(wb_src),
    .branch_target(branch_target), .jump_target(jump_target)
  );

  mips_regfile regfile (
    .clk(clk), .reset(reset), .clk_enable(clk_enable), .reg_write(reg_write),
    .rs_addr(rs_addr), .rt_addr(rt_addr), .dst_addr(dst_addr),
    .write_data(write_data),
    .rs_data(rs_data), .rt_data(rt_data), .register_v0(register_v0)
  );

  mips_alu alu (
    .alu_op(alu_op), .a(rs_data), .b(alu_b), .shamt(shamt),
    .result(alu_result), .zero(zero)
  );

  mips_mem_stage mem_stage (
    .clk_enable(clk_enable), .mem_read(mem_read), .mem_write(mem_write),
    .wb_src(wb_src), .alu_result(alu_result), .rt_data(rt_data),
    .data_readdata(data_readdata), .pc_plus8(pc_plus8),
    .data_address(data_address), .data_writedata(data_writedata),
    .write_data(write_data), .data_read(data_read), .data_write(data_write)
  );

endmodule

`default_nettype wire

//--- verification/mips_cpu_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "mips_cfg.svh"

module mips_cpu_tb;

  import mips_pkg::*;

  localparam int MAX_CYCLES = 1000;

  logic        clk = 1'b0;
  logic        reset;
  logic        clk_enable;
  logic        active;
  logic [31:0] register_v0;
  logic [31:0] instr_address;
  logic [31:0] instr_readdata;
  logic [31:0] instr_offset;
  logic [31:0] data_address;
  logic        data_write;
  logic        data_read;
  logic [31:0] data_writedata;
  logic [31:0] data_readdata;

  logic [31:0] imem [0:255];
  logic [31:0] dmem [0:255];
  logic [31:0] dmem_init [0:255];
  logic [31:0] lfsr_state = 32'hfbc8;
  int          prog_len;
  int          error_count;
  int          check_count;
  int          test_count;
  int          load_count;
  int          store_count;

  always #5 clk = ~clk;

  mips_cpu_harvard uut (
    .clk(clk), .reset(reset), .clk_enable(clk_enable), .active(active),
    .register_v0(register_v0), .instr_address(instr_address),
    .instr_readdata(instr_readdata), .data_address(data_address),
    .data_write(data_write), .data_read(data_read),
    .data_writedata(data_writedata), .data_readdata(data_readdata)
  );

  // Program image starts at the reset vector, anything outside reads as nop
  assign instr_offset   = instr_address - `RESET_VECTOR;
  assign instr_readdata = (instr_offset < 32'd1024) ? imem[instr_offset[9:2]] : 32'h0;
  assign data_readdata  = (data_address < 32'd1024) ? dmem[data_address[9:2]] : 32'h0;

  // Data memory reloads its initial image during reset
  always @(posedge clk)
  begin
    if (reset)
    begin
      for (int i = 0; i < 256; i++)
        dmem[i[7:0]] <= dmem_init[i[7:0]];
      load_count  <= 0;
      store_count <= 0;
    end
    else
    begin
      if (data_read && clk_enable)
        load_count <= load_count + 1;
      // Every edge with the store strobe high counts, frozen or not
      if (data_write)
        store_count <= store_count + 1;
      if (data_write && clk_enable && (data_address < 32'd1024))
        dmem[data_address[9:2]] <= data_writedata;
    end
  end

  function automatic logic [31:0] r_type_word(input funct_t fn, input logic [4:0] rd,
                                              input logic [4:0] rs, input logic [4:0] rt,
                                              input logic [4:0] sh);
    return {op_special, rs, rt, rd, sh, fn};
  endfunction

  function automatic logic [31:0] i_type_word(input opcode_t op, input logic [4:0] rt,
                                              input logic [4:0] rs, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [31:0] j_type_word(input opcode_t op, input logic [31:0] target);
    return {op, target[27:2]};
  endfunction

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] random_bits(input int count);
    logic [31:0] value;
    value = 32'h0;
    for (int i = 0; i < count; i++)
    begin
      value = {value[30:0], lfsr_state[0]};
      if (lfsr_state[0])
        lfsr_state = (lfsr_state >> 1) ^ 32'ha3000000;
      else
        lfsr_state = lfsr_state >> 1;
    end
    return value;
  endfunction

  // r8 to r14, or v0 for one value in eight
  function automatic logic [4:0] random_reg();
    logic [31:0] v;
    v = random_bits(3);
    return (v[2:0] == 3'd7) ? 5'd2 : {2'b01, v[2:0]};
  endfunction

  // Instruction-set model with one delay slot per branch or jump
  function automatic logic [31:0] reference_run(input logic [31:0] probe_addr,
                                                output logic [31:0] probe_word,
                                                output int loads,
                                                output int stores);
    logic [31:0] r [0:`REG_COUNT-1];
    logic [31:0] dm [0:255];
    logic [31:0] pc;
    logic [31:0] npc;
    logic [31:0] seq;
    logic [31:0] off;
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] simm;
    logic [31:0] ea;
    logic [31:0] res;
    logic [31:0] target;
    logic [4:0]  dest;
    logic        wr;
    logic        taken;
    int          steps;
    for (int i = 0; i < `REG_COUNT; i++)
      r[i[4:0]] = 32'h0;
    for (int i = 0; i < 256; i++)
      dm[i[7:0]] = dmem_init[i[7:0]];
    pc     = `RESET_VECTOR;
    npc    = pc + 32'd4;
    steps  = 0;
    loads  = 0;
    stores = 0;
    while ((pc != `HALT_ADDR) && (steps < MAX_CYCLES))
    begin
      off    = pc - `RESET_VECTOR;
      w      = (off < 32'd1024) ? imem[off[9:2]] : 32'h0;
      seq    = pc + 32'd4;
      a      = r[w[25:21]];
      b      = r[w[20:16]];
      simm   = {{16{w[15]}}, w[15:0]};
      ea     = a + simm;
      dest   = w[20:16];
      wr     = 1'b1;
      taken  = 1'b0;
      target = 32'h0;
      res    = 32'h0;
      case (opcode_t'(w[31:26]))
        op_special:
        begin
          dest = w[15:11];
          case (funct_t'(w[5:0]))
            f_sll:  res = b << w[10:6];
            f_srl:  res = b >> w[10:6];
            f_addu: res = a + b;
            f_subu: res = a - b;
            f_and:  res = a & b;
            f_or:   res = a | b;
            f_xor:  res = a ^ b;
            f_slt:  res = {31'h0, $signed(a) < $signed(b)};
            f_sltu: res = {31'h0, a < b};
            f_jr:
            begin
              wr     = 1'b0;
              taken  = 1'b1;
              target = a;
            end
            default: wr = 1'b0;
          endcase
        end
        op_j, op_jal:
        begin
          // Link skips the delay slot
          wr     = (w[31:26] == op_jal);
          dest   = 5'd31;
          res    = pc + 32'd8;
          taken  = 1'b1;
          target = {seq[31:28], w[25:0], 2'b00};
        end
        op_beq, op_bne:
        begin
          wr     = 1'b0;
          taken  = (a == b) ^ w[26];
          target = seq + {simm[29:0], 2'b00};
        end
        op_addiu: res = ea;
        op_slti:  res = {31'h0, $signed(a) < $signed(simm)};
        op_andi:  res = a & {16'h0, w[15:0]};
        op_ori:   res = a | {16'h0, w[15:0]};
        op_xori:  res = a ^ {16'h0, w[15:0]};
        op_lui:   res = {w[15:0], 16'h0};
        op_lw:
        begin
          res   = (ea < 32'd1024) ? dm[ea[9:2]] : 32'h0;
          loads = loads + 1;
        end
        op_sw:
        begin
          wr     = 1'b0;
          stores = stores + 1;
          if (ea < 32'd1024)
            dm[ea[9:2]] = b;
        end
        default: wr = 1'b0;
      endcase
      if (wr && (dest != 5'd0))
        r[dest] = res;
      pc    = npc;
      npc   = taken ? target : npc + 32'd4;
      steps = steps + 1;
    end
    probe_word = dm[probe_addr[9:2]];
    return r[`REG_V0];
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    if (expected !== actual)
    begin
      $display("** Error %s: expected %h, actual %h", name, expected, actual);
      error_count++;
    end
  endtask

  task automatic begin_program();
    for (int i = 0; i < 256; i++)
      imem[i[7:0]] = 32'h0;
    prog_len = 0;
  endtask

  task automatic emit(input logic [31:0] word);
    imem[prog_len[7:0]] = word;
    prog_len++;
  endtask

  task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
    emit(i_type_word(op_lui, rd, 5'd0, value[31:16]));
    emit(i_type_word(op_ori, rd, rd, value[15:0]));
  endtask

  // Jump to address 0 with a nop in the slot
  task automatic emit_halt();
    emit(r_type_word(f_jr, 5'd0, 5'd0, 5'd0, 5'd0));
    emit(32'h0);
  endtask

  // Slot, fall-through and target each add their own tag to v0
  task automatic emit_branch_block(input opcode_t op, input logic [4:0] rs,
                                   input logic [4:0] rt, input logic [15:0] tag);
    emit(i_type_word(op, rt, rs, 16'd2));
    emit(i_type_word(op_addiu, 5'd2, 5'd2, tag));
    emit(i_type_word(op_addiu, 5'd2, 5'd2, tag << 4));
    emit(i_type_word(op_addiu, 5'd2, 5'd2, tag << 8));
  endtask

  task automatic emit_random_alu();
    logic [31:0] sel;
    logic [31:0] imm;
    logic [31:0] sh;
    logic [4:0]  rd;
    logic [4:0]  rs;
    logic [4:0]  rt;
    sel = random_bits(4);
    rd  = random_reg();
    rs  = random_reg();
    rt  = random_reg();
    imm = random_bits(16);
    sh  = random_bits(5);
    case (sel[3:0])
      4'd0:  emit(r_type_word(f_addu, rd, rs, rt, 5'd0));
      4'd1:  emit(r_type_word(f_subu, rd, rs, rt, 5'd0));
      4'd2:  emit(r_type_word(f_and, rd, rs, rt, 5'd0));
      4'd3:  emit(r_type_word(f_or, rd, rs, rt, 5'd0));
      4'd4:  emit(r_type_word(f_xor, rd, rs, rt, 5'd0));
      4'd5:  emit(r_type_word(f_slt, rd, rs, rt, 5'd0));
      4'd6:  emit(r_type_word(f_sltu, rd, rs, rt, 5'd0));
      4'd7:  emit(r_type_word(f_sll, rd, 5'd0, rt, sh[4:0]));
      4'd8:  emit(r_type_word(f_srl, rd, 5'd0, rt, sh[4:0]));
      4'd9:  emit(i_type_word(op_addiu, rd, rs, imm[15:0]));
      4'd10: emit(i_type_word(op_andi, rd, rs, imm[15:0]));
      4'd11: emit(i_type_word(op_ori, rd, rs, imm[15:0]));
      4'd12: emit(i_type_word(op_xori, rd, rs, imm[15:0]));
      4'd13: emit(i_type_word(op_slti, rd, rs, imm[15:0]));
      4'd14: emit(i_type_word(op_lui, rd, 5'd0, imm[15:0]));
      default: emit(r_type_word(f_subu, rd, rs, rt, 5'd0));
    endcase
  endtask

  // Reset, run until active falls, then compare with the reference
  task automatic run_and_check(input string name, input logic [31:0] probe_addr,
                               input logic check_mem, input logic stall);
    logic [31:0] exp_v0;
    logic [31:0] exp_word;
    int          exp_loads;
    int          exp_stores;
    int          errors_before;
    int          cycles;
    errors_before = error_count;
    exp_v0        = reference_run(probe_addr, exp_word, exp_loads, exp_stores);
    reset      = 1'b1;
    clk_enable = 1'b1;
    repeat (3)
    begin
      @(posedge clk);
      #1;
    end
    reset = 1'b0;
    check_value({name, " reset vector"}, `RESET_VECTOR, instr_address);
    cycles = 0;
    while (active && (cycles < MAX_CYCLES))
    begin
      if (stall)
        clk_enable = (random_bits(2) != 32'd0);
      @(posedge clk);
      #1;
      cycles++;
    end
    clk_enable = 1'b1;
    if (active)
    begin
      $display("Test %s: program did not halt within %0d cycles", name, MAX_CYCLES);
      error_count++;
    end
    else
    begin
      check_value(name, exp_v0, register_v0);
      check_value({name, " loads"}, exp_loads, load_count);
      check_value({name, " stores"}, exp_stores, store_count);
      if (check_mem)
        check_value({name, " memory"}, exp_word, dmem[probe_addr[9:2]]);
    end
    test_count++;
    $display("Test %s finished with %0d errors", name, error_count - errors_before);
  endtask

  initial
  begin
    reset       = 1'b1;
    clk_enable  = 1'b1;
    error_count = 0;
    check_count = 0;
    test_count  = 0;
    for (int i = 0; i < 256; i++)
      dmem_init[i[7:0]] = {i[7:0] ^ 8'ha5, 8'h3c, ~i[7:0], i[7:0]};

    begin_program();
    load_const(5'd8, 32'h87654321);
    load_const(5'd9, 32'h1234abcd);
    emit(r_type_word(f_addu, 5'd10, 5'd8, 5'd9, 5'd0));
    emit(r_type_word(f_subu, 5'd11, 5'd8, 5'd9, 5'd0));
    emit(r_type_word(f_and, 5'd12, 5'd10, 5'd11, 5'd0));
    emit(r_type_word(f_or, 5'd13, 5'd12, 5'd9, 5'd0));
    emit(r_type_word(f_xor, 5'd14, 5'd13, 5'd8, 5'd0));
    emit(r_type_word(f_slt, 5'd15, 5'd8, 5'd9, 5'd0));
    emit(r_type_word(f_sltu, 5'd16, 5'd8, 5'd9, 5'd0));
    emit(r_type_word(f_sll, 5'd17, 5'd0, 5'd14, 5'd7));
    emit(r_type_word(f_srl, 5'd18, 5'd0, 5'd17, 5'd3));
    emit(r_type_word(f_addu, 5'd2, 5'd18, 5'd15, 5'd0));
    emit(r_type_word(f_subu, 5'd2, 5'd2, 5'd16, 5'd0));
    emit_halt();
    run_and_check("rtype", 32'h0, 1'b0, 1'b0);

    begin_program();
    emit(i_type_word(op_lui, 5'd8, 5'd0, 16'h8001));
    emit(i_type_word(op_ori, 5'd8, 5'd8, 16'hff00));
    emit(i_type_word(op_addiu, 5'd9, 5'd8, 16'h8004));
    emit(i_type_word(op_andi, 5'd10, 5'd9, 16'hf0f0));
    emit(i_type_word(op_xori, 5'd11, 5'd9, 16'hffff));
    emit(i_type_word(op_slti, 5'd12, 5'd8, 16'h0005));
    emit(i_type_word(op_slti, 5'd13, 5'd10, 16'hffff));
    emit(i_type_word(op_ori, 5'd14, 5'd0, 16'h8000));
    emit(r_type_word(f_addu, 5'd2, 5'd10, 5'd11, 5'd0));
    emit(r_type_word(f_addu, 5'd2, 5'd2, 5'd12, 5'd0));
    emit(r_type_word(f_addu, 5'd2, 5'd2, 5'd13, 5'd0));
    emit(r_type_word(f_xor, 5'd2, 5'd2, 5'd14, 5'd0));
    emit_halt();
    run_and_check("immediate", 32'h0, 1'b0, 1'b0);

    // Stalls here also cover loads and stores while frozen
    begin_program();
    load_const(5'd8, 32'hcafe0123);
    emit(i_type_word(op_addiu, 5'd9, 5'd0, 16'h0040));
    emit(i_type_word(op_sw, 5'd8, 5'd9, 16'h0008));
    emit(i_type_word(op_lw, 5'd2, 5'd9, 16'h0008));
    emit(i_type_word(op_lw, 5'd10, 5'd0, 16'h0010));
    emit(r_type_word(f_addu, 5'd2, 5'd2, 5'd10, 5'd0));
    emit(i_type_word(op_sw, 5'd2, 5'd9, 16'h000c));
    emit_halt();
    run_and_check("load_store", 32'h0000004c, 1'b1, 1'b1);

    begin_program();
    emit(i_type_word(op_addiu, 5'd8, 5'd0, 16'd5));
    emit(i_type_word(op_addiu, 5'd9, 5'd0, 16'd5));
    emit(i_type_word(op_addiu, 5'd10, 5'd0, 16'd7));
    emit_branch_block(op_beq, 5'd8, 5'd9, 16'h0001);
    emit_branch_block(op_beq, 5'd8, 5'd10, 16'h0002);
    emit_branch_block(op_bne, 5'd8, 5'd10, 16'h0004);
    emit_branch_block(op_bne, 5'd8, 5'd9, 16'h0008);
    emit_halt();
    run_and_check("branch", 32'h0, 1'b0, 1'b0);

    // Subroutine sits at word 6, after the halt pair
    begin_program();
    emit(i_type_word(op_addiu, 5'd2, 5'd0, 16'd3));
    emit(j_type_word(op_jal, `RESET_VECTOR + 32'd24));
    emit(i_type_word(op_addiu, 5'd2, 5'd2, 16'h0001));
    emit(i_type_word(op_addiu, 5'd2, 5'd2, 16'h0020));
    emit_halt();
    emit(r_type_word(f_addu, 5'd2, 5'd2, 5'd31, 5'd0));
    emit(r_type_word(f_jr, 5'd0, 5'd31, 5'd0, 5'd0));
    emit(i_type_word(op_addiu, 5'd2, 5'd2, 16'h0040));
    run_and_check("jal_jr", 32'h0, 1'b0, 1'b0);

    for (int t = 0; t < 4; t++)
    begin
      begin_program();
      for (int k = 8; k < 15; k++)
        load_const(k[4:0], random_bits(32));
      for (int k = 0; k < 24; k++)
        emit_random_alu();
      // Fold every working register into v0
      for (int k = 8; k < 15; k++)
        emit(r_type_word(f_xor, 5'd2, 5'd2, k[4:0], 5'd0));
      emit_halt();
      run_and_check($sformatf("random_%0d", t), 32'h0, 1'b0, 1'b1);
    end

    $display("Tests run: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
    if (error_count == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- mips_cpu_harvard.f
+incdir+src
src/mips_pkg.sv
src/mips_fetch.sv
src/mips_decode.sv
src/mips_regfile.sv
src/mips_alu.sv
src/mips_mem_stage.sv
src/mips_cpu_harvard.sv
verification/mips_cpu_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ns \
  -f mips_cpu_harvard.f --top-module mips_cpu_tb -o mips_cpu_tb
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit 1
fi

output=$(./obj_dir/mips_cpu_tb)
run_status=$?
printf '%s\n' "$output"
if [ $run_status -ne 0 ]; then
  echo "Simulation run exited with status $run_status"
  exit 1
fi

if printf '%s\n' "$output" | grep -q "^Simulation passed$"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
